//--- mips_settings.svh
// Reset vector, word step, register count and data-width macros.
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// **************************************************
// Datapath widths
// **************************************************

`define MIPS_XLEN 32
`define MIPS_NREGS 32

// **************************************************
// Fetch constants
// **************************************************

// PC value after reset. The delay slot starts one word later.
`define MIPS_RESET_VECTOR (32'hBFC0_0000)
`define MIPS_WORD_BYTES (32'd4)

`endif

//--- mips_isa_pkg.sv
// Primary opcode and R-type function code enums.
package mips_isa_pkg;

  // **************************************************
  // Primary opcodes in instruction bits 31:26
  // **************************************************

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ANDI    = 6'h0C,
    OP_ORI     = 6'h0D,
    OP_LUI     = 6'h0F
  } opcode_t;

  // **************************************************
  // Function codes for OP_SPECIAL in bits 5:0
  // **************************************************

  typedef enum logic [5:0] {
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2A
  } funct_t;

  // Field positions shared by all formats.
  localparam int OPCODE_LSB = 26;
  localparam int RS_LSB     = 21;
  localparam int RT_LSB     = 16;
  localparam int RD_LSB     = 11;

endpackage

//--- mips_ctrl_pkg.sv
// ALU operation, write-back source and next-PC source enums.
package mips_ctrl_pkg;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_SLT    = 3'd4,
    ALU_PASS_B = 3'd5
  } alu_op_t;

  // Register write value.
  typedef enum logic {
    WB_ALU = 1'b0,
    WB_LUI = 1'b1
  } wb_src_t;

  // What the delay-slot register loads next.
  typedef enum logic [1:0] {
    PC_SEQ    = 2'd0,
    PC_BRANCH = 2'd1,
    PC_JUMP   = 2'd2,
    PC_REG    = 2'd3
  } pc_src_t;

endpackage

//--- mips_fetch.sv
// PC and delay-slot registers, next-PC selection and the active flag.
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_fetch (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clk_enable,
  input  mips_ctrl_pkg::pc_src_t pc_src,
  input  logic                   branch_ne,
  input  logic                   zero,
  input  logic [25:0]            jump_index,
  input  logic [`MIPS_XLEN-1:0]  rs_data,
  input  logic [`MIPS_XLEN-1:0]  imm_ext,
  output logic [`MIPS_XLEN-1:0]  instr_addr,
  output logic                   active
);
  import mips_ctrl_pkg::*;

  logic [`MIPS_XLEN-1:0] pc_q;
  logic [`MIPS_XLEN-1:0] ds_q;
  logic [`MIPS_XLEN-1:0] seq_addr;
  logic [`MIPS_XLEN-1:0] branch_addr;
  logic [`MIPS_XLEN-1:0] jump_addr;
  logic [`MIPS_XLEN-1:0] next_addr;
  logic                  branch_taken;

  // **************************************************
  // Target arithmetic relative to the delay slot
  // **************************************************

  assign seq_addr    = ds_q + `MIPS_WORD_BYTES;
  assign branch_addr = ds_q + {imm_ext[`MIPS_XLEN-3:0], 2'b00};
  assign jump_addr   = {ds_q[`MIPS_XLEN-1:28], jump_index, 2'b00};

  // BEQ takes on equal operands, BNE on unequal ones.
  assign branch_taken = zero ^ branch_ne;

  always_comb begin
    unique case (pc_src)
      PC_SEQ:    next_addr = seq_addr;
      PC_BRANCH: next_addr = branch_taken ? branch_addr : seq_addr;
      PC_JUMP:   next_addr = jump_addr;
      PC_REG:    next_addr = rs_data;
      default:   next_addr = seq_addr;
    endcase
  end

  // **************************************************
  // PC, delay slot and halt
  // **************************************************

  // The PC always takes the delay slot, so a redirect lands one
  // instruction late.
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q   <= `MIPS_RESET_VECTOR;
      ds_q   <= `MIPS_RESET_VECTOR + `MIPS_WORD_BYTES;
      active <= 1'b1;
    end else if (clk_enable && active) begin
      pc_q <= ds_q;
      ds_q <= next_addr;
      if (ds_q == '0) begin
        active <= 1'b0;
      end
    end
  end

  assign instr_addr = pc_q;

endmodule

//--- mips_decode.sv
// Instruction decoder for control enums, register addresses and immediate.
`timescale 1ns/1ps

module mips_decode (
  input  logic [31:0]            instr_data,
  output mips_ctrl_pkg::pc_src_t pc_src,
  output logic                   branch_ne,
  output logic [25:0]            jump_index,
  output mips_ctrl_pkg::alu_op_t alu_op,
  output logic                   alu_src_imm,
  output logic [31:0]            imm_ext,
  output mips_ctrl_pkg::wb_src_t wb_src,
  output logic                   reg_we,
  output logic [4:0]             rs,
  output logic [4:0]             rt,
  output logic [4:0]             wd_addr
);
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  opcode_t     opcode;
  funct_t      funct;
  logic [4:0]  rd;
  logic [15:0] imm;
  logic        imm_zero_ext;

  assign opcode     = opcode_t'(instr_data[31:OPCODE_LSB]);
  assign funct      = funct_t'(instr_data[5:0]);
  assign rs         = instr_data[RS_LSB+4:RS_LSB];
  assign rt         = instr_data[RT_LSB+4:RT_LSB];
  assign rd         = instr_data[RD_LSB+4:RD_LSB];
  assign imm        = instr_data[15:0];
  assign jump_index = instr_data[25:0];
  assign branch_ne  = (opcode == OP_BNE);

  // Logical immediates are zero-extended.
  assign imm_zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI);
  assign imm_ext      = imm_zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};

  always_comb begin
    pc_src      = PC_SEQ;
    alu_op      = ALU_PASS_B;
    alu_src_imm = 1'b0;
    wb_src      = WB_ALU;
    reg_we      = 1'b0;
    wd_addr     = rt;
    case (opcode)
      OP_SPECIAL: begin
        wd_addr = rd;
        reg_we  = 1'b1;
        case (funct)
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_JR: begin
            pc_src = PC_REG;
            reg_we = 1'b0;
          end
          default: reg_we = 1'b0;
        endcase
      end
      OP_J:           pc_src = PC_JUMP;
      OP_BEQ, OP_BNE: pc_src = PC_BRANCH;
      OP_ADDIU, OP_ANDI, OP_ORI: begin
        alu_src_imm = 1'b1;
        reg_we      = 1'b1;
        if (opcode == OP_ADDIU) begin
          alu_op = ALU_ADD;
        end else if (opcode == OP_ANDI) begin
          alu_op = ALU_AND;
        end else begin
          alu_op = ALU_OR;
        end
      end
      OP_LUI: begin
        wb_src = WB_LUI;
        reg_we = 1'b1;
      end
      default: reg_we = 1'b0;
    endcase
  end

endmodule

//--- mips_alu.sv
// ALU with result and the branch equality flag.
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_alu (
  input  mips_ctrl_pkg::alu_op_t alu_op,
  input  logic                   alu_src_imm,
  input  logic [`MIPS_XLEN-1:0]  rs_data,
  input  logic [`MIPS_XLEN-1:0]  rt_data,
  input  logic [`MIPS_XLEN-1:0]  imm_ext,
  output logic [`MIPS_XLEN-1:0]  alu_result,
  output logic                   zero
);
  import mips_ctrl_pkg::*;

  logic [`MIPS_XLEN-1:0] op_b;
  logic                  less;

  assign op_b = alu_src_imm ? imm_ext : rt_data;

  // Signed compare for SLT.
  assign less = $signed(rs_data) < $signed(op_b);

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = rs_data + op_b;
      ALU_SUB:    alu_result = rs_data - op_b;
      ALU_AND:    alu_result = rs_data & op_b;
      ALU_OR:     alu_result = rs_data | op_b;
      ALU_SLT:    alu_result = {{(`MIPS_XLEN-1){1'b0}}, less};
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = op_b;
    endcase
  end

  // Branches always compare the two registers, whatever operand B is.
  assign zero = (rs_data == rt_data);

endmodule

//--- mips_regfile.sv
// Register file with write-back selection, two read ports and the v0 tap.
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_regfile (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clk_enable,
  input  logic                   active,
  input  logic                   reg_we,
  input  mips_ctrl_pkg::wb_src_t wb_src,
  input  logic [4:0]             wd_addr,
  input  logic [4:0]             rs,
  input  logic [4:0]             rt,
  input  logic [`MIPS_XLEN-1:0]  alu_result,
  input  logic [`MIPS_XLEN-1:0]  imm_ext,
  output logic [`MIPS_XLEN-1:0]  rs_data,
  output logic [`MIPS_XLEN-1:0]  rt_data,
  output logic [`MIPS_XLEN-1:0]  reg_v0
);
  import mips_ctrl_pkg::*;

  logic [`MIPS_XLEN-1:0] rf [`MIPS_NREGS];
  logic [`MIPS_XLEN-1:0] wd;
  logic                  we;

  assign wd = (wb_src == WB_LUI) ? (imm_ext << 16) : alu_result;
  assign we = reg_we && clk_enable && active;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_NREGS; i++) begin
        rf[i] <= '0;
      end
    end else if (we) begin
      rf[wd_addr] <= wd;
    end
  end

  // Register 0 reads as zero even after a write.
  assign rs_data = (rs != 5'd0) ? rf[rs] : '0;
  assign rt_data = (rt != 5'd0) ? rf[rt] : '0;
  assign reg_v0  = rf[2];

endmodule

//--- mips_core.sv
// Core top level wiring fetch, decode, ALU and register file.
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_core (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  clk_enable,
  input  logic [31:0]           instr_data,
  output logic [`MIPS_XLEN-1:0] instr_addr,
  output logic                  active,
  output logic [`MIPS_XLEN-1:0] reg_v0
);
  import mips_ctrl_pkg::*;

  pc_src_t               pc_src;
  logic                  branch_ne;
  logic [25:0]           jump_index;
  alu_op_t               alu_op;
  logic                  alu_src_imm;
  logic [`MIPS_XLEN-1:0] imm_ext;
  wb_src_t               wb_src;
  logic                  reg_we;
  logic [4:0]            rs;
  logic [4:0]            rt;
  logic [4:0]            wd_addr;
  logic [`MIPS_XLEN-1:0] rs_data;
  logic [`MIPS_XLEN-1:0] rt_data;
  logic [`MIPS_XLEN-1:0] alu_result;
  logic                  zero;

  // **************************************************
  // Fetch
  // **************************************************

  mips_fetch u_fetch (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .pc_src     (pc_src),
    .branch_ne  (branch_ne),
    .zero       (zero),
    .jump_index (jump_index),
    .rs_data    (rs_data),
    .imm_ext    (imm_ext),
    .instr_addr (instr_addr),
    .active     (active)
  );

  // **************************************************
  // Decode and execute
  // **************************************************

  mips_decode u_decode (
    .instr_data  (instr_data),
    .pc_src      (pc_src),
    .branch_ne   (branch_ne),
    .jump_index  (jump_index),
    .alu_op      (alu_op),
    .alu_src_imm (alu_src_imm),
    .imm_ext     (imm_ext),
    .wb_src      (wb_src),
    .reg_we      (reg_we),
    .rs          (rs),
    .rt          (rt),
    .wd_addr     (wd_addr)
  );

  mips_alu u_alu (
    .alu_op      (alu_op),
    .alu_src_imm (alu_src_imm),
    .rs_data     (rs_data),
    .rt_data     (rt_data),
    .imm_ext     (imm_ext),
    .alu_result  (alu_result),
    .zero        (zero)
  );

  // **************************************************
  // Register file and write-back
  // **************************************************

  mips_regfile u_regfile (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .active     (active),
    .reg_we     (reg_we),
    .wb_src     (wb_src),
    .wd_addr    (wd_addr),
    .rs         (rs),
    .rt         (rt),
    .alu_result (alu_result),
    .imm_ext    (imm_ext),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .reg_v0     (reg_v0)
  );

endmodule

//--- tb_mips_asserts.sv
// Concurrent assertions on the core's fetch and halt behaviour, bound to the core.
`timescale 1ns/1ps
`include "mips_settings.svh"

module tb_mips_asserts (
  input logic                  clk,
  input logic                  reset,
  input logic                  active,
  input logic [`MIPS_XLEN-1:0] instr_addr,
  input logic [`MIPS_XLEN-1:0] reg_v0
);

  int unsigned fail_count = 0;

  reset_vector_check: assert property (@(posedge clk)
    $fell(reset) |-> instr_addr == `MIPS_RESET_VECTOR)
    else begin
      fail_count++;
      $error("instr_addr is not the reset vector after reset");
    end

  aligned_check: assert property (@(posedge clk) disable iff (reset)
    instr_addr[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("instr_addr is not word aligned");
    end

  // Only reset may bring the core back to life.
  active_rise_check: assert property (@(posedge clk)
    $rose(active) |-> $past(reset))
    else begin
      fail_count++;
      $error("active rose outside reset");
    end

  halted_write_check: assert property (@(posedge clk) disable iff (reset)
    !active |=> $stable(reg_v0) && $stable(instr_addr))
    else begin
      fail_count++;
      $error("state changed while the core was halted");
    end

endmodule

bind mips_core tb_mips_asserts u_asserts (
  .clk        (clk),
  .reset      (reset),
  .active     (active),
  .instr_addr (instr_addr),
  .reg_v0     (reg_v0)
);

//--- tb_mips_checker.sv
// Checker that compares v0 at the halt and keeps the pass and fail counts.
`timescale 1ns/1ps

module tb_mips_checker (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  logic [31:0] expected,
  input  int          test_id,
  input  logic        active,
  input  logic [31:0] instr_addr,
  input  logic [31:0] reg_v0,
  output int          n_pass,
  output int          n_fail
);

  int          pass_q = 0;
  int          fail_q = 0;
  logic        armed;
  logic        bad_start;
  logic [31:0] exp_q;
  int          id_q;

  assign n_pass = pass_q;
  assign n_fail = fail_q;

  always @(posedge clk) begin
    if (reset) begin
      armed <= 1'b0;
    end else if (start) begin
      // A fresh reset leaves v0 clear and the core running.
      exp_q     <= expected;
      id_q      <= test_id;
      armed     <= 1'b1;
      bad_start <= (reg_v0 !== 32'd0) || (active !== 1'b1);
      if ((reg_v0 !== 32'd0) || (active !== 1'b1)) begin
        $display("Error at %0t: test %0d starts with v0 = %h, active = %b",
                 $time, test_id, reg_v0, active);
      end
    end else if (armed && !active) begin
      armed <= 1'b0;
      if (instr_addr !== 32'd0) begin
        $display("test %0d: the core halted at %h before the program ended", id_q, instr_addr);
        fail_q <= fail_q + 1;
      end else if (reg_v0 !== exp_q) begin
        $display("Error at %0t: test %0d v0 = %h, expected %h", $time, id_q, reg_v0, exp_q);
        fail_q <= fail_q + 1;
      end else if (bad_start) begin
        $display("test %0d: failed, state was not clear after reset", id_q);
        fail_q <= fail_q + 1;
      end else begin
        $display("test %0d: passed, v0 = %h", id_q, reg_v0);
        pass_q <= pass_q + 1;
      end
    end
  end

endmodule

//--- tb_mips.sv
// Testbench top with clock, reset, LFSR, test table, program ROM, stimulus loop and watchdog.
`timescale 1ns/1ps
`include "mips_settings.svh"

module tb_mips;
  import mips_isa_pkg::*;

  localparam int N_TESTS   = 18;
  localparam int ROM_WORDS = 16;

  typedef enum logic [3:0] {
    K_ADDU, K_SUBU, K_AND, K_OR, K_SLT, K_CONST, K_ANDI, K_ADDIU,
    K_BEQ, K_BNE, K_SLOT, K_R0
  } kind_t;

  typedef struct packed {
    kind_t       kind;
    logic [31:0] a;
    logic [31:0] b;
    logic        stall;
    logic        rnd;
  } row_t;

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic [31:0] instr_data;
  logic [31:0] instr_addr;
  logic        active;
  logic [31:0] reg_v0;
  logic        start;
  logic [31:0] expected;
  int          test_id;
  int          n_pass;
  int          n_fail;
  logic [15:0] lfsr;
  logic [31:0] rom [ROM_WORDS];
  logic [3:0]  rom_len;
  logic [31:0] rom_index;
  row_t        tests [N_TESTS];

  mips_core u_dut (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .instr_data (instr_data),
    .instr_addr (instr_addr),
    .active     (active),
    .reg_v0     (reg_v0)
  );

  tb_mips_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .expected   (expected),
    .test_id    (test_id),
    .active     (active),
    .instr_addr (instr_addr),
    .reg_v0     (reg_v0),
    .n_pass     (n_pass),
    .n_fail     (n_fail)
  );

  always #50 clk = ~clk;

  // Word 0 of the program ROM sits at the reset vector.
  assign rom_index  = (instr_addr - `MIPS_RESET_VECTOR) >> 2;
  assign instr_data = (rom_index < ROM_WORDS) ? rom[rom_index[3:0]] : fill_word(instr_addr);

  // **************************************************
  // Random bits and instruction encoding
  // **************************************************

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bit(output logic b);
    b    = lfsr[15];
    lfsr = lfsr_next(lfsr);
  endtask

  task automatic draw_word(output logic [31:0] w);
    logic b;
    for (int i = 0; i < 32; i++) begin
      take_bit(b);
      w = {w[30:0], b};
    end
  endtask

  function automatic logic [31:0] enc_r(funct_t fn, logic [4:0] rd, logic [4:0] rs,
                                        logic [4:0] rt);
    return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] enc_i(opcode_t op, logic [4:0] rt, logic [4:0] rs,
                                        logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Unused and unmapped words hold a v0 update that a halted core must ignore.
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return enc_i(OP_ADDIU, 5'd2, 5'd2, addr[31:16] ^ addr[15:0] ^ 16'h5A5A);
  endfunction

  task automatic emit(input logic [31:0] instr);
    rom[rom_len] = instr;
    rom_len      = rom_len + 4'd1;
  endtask

  task automatic build_program(input kind_t kind, input logic [31:0] a, input logic [31:0] b);
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i[3:0]] = fill_word(`MIPS_RESET_VECTOR + i * 4);
    end
    rom_len = 4'd0;
    emit(enc_i(OP_LUI, 5'd4, 5'd0, a[31:16]));
    emit(enc_i(OP_ORI, 5'd4, 5'd4, a[15:0]));
    emit(enc_i(OP_LUI, 5'd5, 5'd0, b[31:16]));
    emit(enc_i(OP_ORI, 5'd5, 5'd5, b[15:0]));
    case (kind)
      K_ADDU:  emit(enc_r(FN_ADDU, 5'd2, 5'd4, 5'd5));
      K_SUBU:  emit(enc_r(FN_SUBU, 5'd2, 5'd4, 5'd5));
      K_AND:   emit(enc_r(FN_AND, 5'd2, 5'd4, 5'd5));
      K_OR:    emit(enc_r(FN_OR, 5'd2, 5'd4, 5'd5));
      K_SLT:   emit(enc_r(FN_SLT, 5'd2, 5'd4, 5'd5));
      K_ANDI:  emit(enc_i(OP_ANDI, 5'd2, 5'd4, b[15:0]));
      K_ADDIU: emit(enc_i(OP_ADDIU, 5'd2, 5'd4, b[15:0]));
      K_CONST: begin
        emit(enc_i(OP_LUI, 5'd2, 5'd0, a[31:16]));
        emit(enc_i(OP_ORI, 5'd2, 5'd2, a[15:0]));
      end
      K_R0: begin
        emit(enc_r(FN_ADDU, 5'd2, 5'd4, 5'd5));
        emit(enc_r(FN_ADDU, 5'd0, 5'd4, 5'd5));
        emit(enc_r(FN_OR, 5'd2, 5'd0, 5'd0));
      end
      default: begin
        // Branch at word 4, delay slot at word 5, target at word 9.
        emit(enc_i(kind == K_BNE ? OP_BNE : OP_BEQ, kind == K_SLOT ? 5'd4 : 5'd5,
                   5'd4, 16'd4));
        emit(enc_i(OP_ADDIU, 5'd6, 5'd6, 16'd1));
        emit(enc_i(OP_ADDIU, 5'd2, 5'd0, 16'd1));
        emit(enc_r(FN_JR, 5'd0, 5'd0, 5'd0));
        emit(32'd0);
        if (kind == K_SLOT) begin
          emit(enc_r(FN_OR, 5'd2, 5'd6, 5'd0));
        end else begin
          emit(enc_i(OP_ADDIU, 5'd2, 5'd0, 16'd2));
        end
      end
    endcase
    emit(enc_r(FN_JR, 5'd0, 5'd0, 5'd0));
    emit(32'd0);
  endtask

  function automatic logic [31:0] expected_v0(kind_t kind, logic [31:0] a, logic [31:0] b);
    case (kind)
      K_ADDU:  return a + b;
      K_SUBU:  return a - b;
      K_AND:   return a & b;
      K_OR:    return a | b;
      K_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      K_CONST: return a;
      K_ANDI:  return a & {16'h0000, b[15:0]};
      K_ADDIU: return a + {{16{b[15]}}, b[15:0]};
      K_BEQ:   return (a == b) ? 32'd2 : 32'd1;
      K_BNE:   return (a != b) ? 32'd2 : 32'd1;
      K_SLOT:  return 32'd1;
      default: return 32'd0;
    endcase
  endfunction

  // **************************************************
  // Test table
  // **************************************************

  task automatic load_tests();
    tests[0]  = '{K_ADDU,  32'd5,         32'd7,         1'b0, 1'b0};
    tests[1]  = '{K_SUBU,  32'd3,         32'd10,        1'b0, 1'b0};
    tests[2]  = '{K_AND,   32'hF0F0_FF00, 32'h0FF0_0F0F, 1'b0, 1'b0};
    tests[3]  = '{K_OR,    32'h1234_0000, 32'h0000_5678, 1'b0, 1'b0};
    tests[4]  = '{K_SLT,   32'hFFFF_FFFB, 32'd3,         1'b0, 1'b0};
    tests[5]  = '{K_SLT,   32'd3,         32'hFFFF_FFFB, 1'b0, 1'b0};
    tests[6]  = '{K_CONST, 32'hDEAD_BEEF, 32'd0,         1'b0, 1'b0};
    tests[7]  = '{K_ANDI,  32'hFFFF_FFFF, 32'h0000_8001, 1'b0, 1'b0};
    tests[8]  = '{K_ADDIU, 32'd100,       32'hFFFF_FFF0, 1'b0, 1'b0};
    tests[9]  = '{K_BEQ,   32'd7,         32'd7,         1'b0, 1'b0};
    tests[10] = '{K_BEQ,   32'd7,         32'd8,         1'b0, 1'b0};
    tests[11] = '{K_BNE,   32'd7,         32'd8,         1'b0, 1'b0};
    tests[12] = '{K_BNE,   32'd9,         32'd9,         1'b0, 1'b0};
    tests[13] = '{K_SLOT,  32'd1,         32'd2,         1'b0, 1'b0};
    tests[14] = '{K_R0,    32'h0000_0011, 32'h0000_0022, 1'b0, 1'b0};
    tests[15] = '{K_ADDU,  32'd0,         32'd0,         1'b1, 1'b1};
    tests[16] = '{K_SLT,   32'd0,         32'd0,         1'b1, 1'b1};
    tests[17] = '{K_BNE,   32'd0,         32'd0,         1'b1, 1'b1};
  endtask

  // **************************************************
  // Stimulus
  // **************************************************

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic        bit_val;
    clk        = 1'b0;
    reset      = 1'b1;
    clk_enable = 1'b1;
    start      = 1'b0;
    expected   = 32'd0;
    test_id    = 0;
    lfsr       = 16'd46;
    load_tests();
    for (int i = 0; i < N_TESTS; i++) begin
      a = tests[i].a;
      b = tests[i].b;
      if (tests[i].rnd) begin
        draw_word(a);
        draw_word(b);
      end
      reset      = 1'b1;
      clk_enable = 1'b1;
      build_program(tests[i].kind, a, b);
      repeat (4) @(posedge clk);
      #1;
      reset    = 1'b0;
      start    = 1'b1;
      expected = expected_v0(tests[i].kind, a, b);
      test_id  = i;
      @(posedge clk);
      #1;
      start = 1'b0;
      while ((n_pass + n_fail) <= i) begin
        if (tests[i].stall) begin
          take_bit(bit_val);
          clk_enable = bit_val;
        end
        @(posedge clk);
        #1;
      end
      // Halted core stays out of reset for two enabled cycles.
      clk_enable = 1'b1;
      repeat (2) @(posedge clk);
      #1;
    end
    $display("Tests: %0d passed, %0d failed, %0d assertion failures",
             n_pass, n_fail, u_dut.u_asserts.fail_count);
    if (n_fail == 0 && n_pass == N_TESTS && u_dut.u_asserts.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    #(N_TESTS * (4 + 40) * 100);
    $display("Watchdog: the tests did not complete within %0d ns", N_TESTS * (4 + 40) * 100);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
mips_isa_pkg.sv
mips_ctrl_pkg.sv
mips_fetch.sv
mips_decode.sv
mips_alu.sv
mips_regfile.sv
mips_core.sv
tb_mips_asserts.sv
tb_mips_checker.sv
tb_mips.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_mips -f sim.f -o Vtb_mips

run: compile
	./obj_dir/Vtb_mips +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
